//--- common/tcb_pkg.sv
// TCB shared bus types
`default_nettype none

package tcb_pkg;

  //////////////////////////////
  // default bus widths
  //////////////////////////////

  // byte address width
  localparam int TCB_ABW = 16;
  // data width, read and write share it
  localparam int TCB_DBW = 32;
  // one byte enable per data byte
  localparam int TCB_BEW = TCB_DBW / 8;

  //////////////////////////////
  // response timing
  //////////////////////////////

  // cycles from transfer edge to valid read data
  localparam int TCB_DLY = 1;

  //////////////////////////////
  // bus vectors
  //////////////////////////////

  // byte address
  typedef logic [TCB_ABW-1:0] tcb_adr_t;

  // write or read data word
  typedef logic [TCB_DBW-1:0] tcb_dat_t;

  // byte lane enables, bit n covers data bits 8n+7:8n
  typedef logic [TCB_BEW-1:0] tcb_ben_t;

endpackage : tcb_pkg

`default_nettype wire

//--- list.f
common/tcb_pkg.sv
verilog/tcb_register_request.sv
verilog/tcb_decoder.sv
verilog/tcb_sram.sv
verilog/tcb_scratch_regs.sv
verilog/tcb_subsystem.sv
test/tcb_clock_gen.sv
test/tcb_subsystem_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the TCB subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -j 0 \
  --top-module tcb_subsystem_tb \
  -Mdir obj_dir \
  -f list.f \
  && ./obj_dir/Vtcb_subsystem_tb \
  || { echo "simulation build or run failed"; exit 1; }

//--- test/tcb_clock_gen.sv
// TCB testbench clock and reset
`timescale 1ns/100ps
`default_nettype none

module tcb_clock_gen #(
  // clock period in ns
  parameter int PERIOD     = 20,
  // reset length in clock cycles
  parameter int RST_CYCLES = 5
)(
  output logic sub,
  output logic rst_n
);

  initial begin
    sub = 1'b0;
    forever #(PERIOD / 2) sub = ~sub;
  end

  // reset released on a rising edge
  initial begin
    rst_n <= 1'b0;
    repeat (RST_CYCLES) @(posedge sub);
    rst_n <= 1'b1;
  end

endmodule : tcb_clock_gen

`default_nettype wire

//--- test/tcb_subsystem_tb.sv
// TCB subsystem testbench
`timescale 1ns/100ps
`default_nettype none

module tcb_subsystem_tb
  import tcb_pkg::*;
();

  localparam int DLY         = 1;
  localparam int SRAM_DEPTH  = 256;
  localparam int IDW         = $clog2(SRAM_DEPTH);
  localparam int SEED        = 91321;
  // sram fill, partial lanes, register bank, random mix
  localparam int NUM_TXN     = 32 + 32 + 8 + 200;
  localparam int CYCLE_LIMIT = NUM_TXN * 6 + 100;

  logic     sub, rst_n;
  logic     vld, rdy, wen, rsp_vld;
  tcb_adr_t adr;
  tcb_ben_t ben;
  tcb_dat_t wdt, rdt;

  // byte image of both spaces
  // the four registers sit after the sram words
  logic [7:0] model_mem [(SRAM_DEPTH + 4) * 4];
  // expected read words in request order
  tcb_dat_t   exp_q [$];
  tcb_dat_t   txn_word;
  tcb_dat_t   rsp_word;
  int         cycles    = 0;
  int         rsp_count = 0;

  tcb_clock_gen #(.PERIOD (20), .RST_CYCLES (5)) u_clock_gen (.sub (sub), .rst_n (rst_n));

  tcb_subsystem #(.DLY (DLY), .SRAM_DEPTH (SRAM_DEPTH)) u_tcb_subsystem (
    .sub (sub), .rst_n (rst_n), .vld (vld), .rdy (rdy), .wen (wen), .adr (adr),
    .ben (ben), .wdt (wdt), .rsp_vld (rsp_vld), .rdt (rdt)
  );

  //////////////////////////////
  // helpers
  //////////////////////////////

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("[FAIL] %0t ns: %s, got %h expected %h", $time, what, got, exp));
    end
  endtask

  // bit 15 picks the space and the word bits pick the entry
  function automatic int word_index(input tcb_adr_t a);
    if (a[15]) return SRAM_DEPTH + int'(a[3:2]);
    return int'(a[IDW+1:2]);
  endfunction

  // reference model applies the enabled lanes of a write
  // and returns the word as it now stands
  function automatic tcb_dat_t model_access(input logic w, input tcb_adr_t a,
                                            input tcb_ben_t b, input tcb_dat_t d);
    int       base;
    tcb_dat_t word;
    base = word_index(a) * 4;
    for (int i = 0; i < TCB_BEW; i++) begin
      if (w && b[i]) model_mem[base+i] = d[8*i +: 8];
      word[8*i +: 8] = model_mem[base+i];
    end
    return word;
  endfunction

  // random don't care address bits exercise the aliases too
  function automatic tcb_adr_t make_adr(input logic reg_space, input int word);
    logic [31:0] r;
    tcb_adr_t    a;
    r = $urandom;
    a = r[15:0];
    a[15] = reg_space;
    if (reg_space) a[3:2] = word[1:0];
    else a[IDW+1:2] = word[IDW-1:0];
    return a;
  endfunction

  // returns just after the transfer edge with vld still high
  task automatic issue(input logic w, input tcb_adr_t a, input tcb_ben_t b, input tcb_dat_t d);
    vld <= 1'b1;
    wen <= w;
    adr <= a;
    ben <= b;
    wdt <= d;
    do begin
      @(posedge sub);
    end while (!rdy);
  endtask

  // register access sits in the slice one cycle with rdy low
  task automatic wait_state_check();
    vld <= 1'b0;
    @(posedge sub);
    check_equal({31'b0, rdy}, 32'd0, "outside rdy during register wait state");
    @(posedge sub);
  endtask

  //////////////////////////////
  // monitors
  //////////////////////////////

  always @(posedge sub) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      stop_run($sformatf("timeout, run passed its limit of %0d cycles", CYCLE_LIMIT));
    end
  end

  // model follows each outside transfer edge in request order
  always @(posedge sub) begin
    if (rst_n && vld && rdy) begin
      txn_word = model_access(wen, adr, ben, wdt);
      if (!wen) exp_q.push_back(txn_word);
    end
  end

  // responses sampled mid cycle where rsp_vld and rdt are settled
  always @(negedge sub) begin
    if (rsp_vld) begin
      if (exp_q.size() == 0) begin
        stop_run("response strobe arrived with no read outstanding");
      end else begin
        rsp_word = exp_q.pop_front();
        rsp_count++;
        check_equal(rdt, rsp_word, $sformatf("read response %0d", rsp_count));
      end
    end
  end

  //////////////////////////////
  // stimulus
  //////////////////////////////

  initial begin
    logic [31:0] r;
    logic        space;
    int          word;
    void'($urandom(SEED));
    vld <= 1'b0;
    wen <= 1'b0;
    adr <= '0;
    ben <= '0;
    wdt <= '0;
    // registers come out of reset at zero
    for (int i = 0; i < $size(model_mem); i++) model_mem[i] = 8'h00;
    do begin
      @(posedge sub);
    end while (!rst_n);

    // quiet bus after reset
    repeat (10) begin
      @(posedge sub);
      check_equal({31'b0, rsp_vld}, 32'd0, "rsp_vld idle after reset");
    end

    // full words into sram 0..15 and read back
    for (int i = 0; i < 16; i++) issue(1'b1, make_adr(1'b0, i), 4'hf, $urandom);
    for (int i = 0; i < 16; i++) issue(1'b0, make_adr(1'b0, i), 4'hf, 32'h0);

    // partial lanes on eight sram words and then the registers twice
    for (int i = 0; i < 16; i++) begin
      space = (i >= 8);
      r = $urandom;
      issue(1'b1, make_adr(space, i % 8), r[3:0], $urandom);
      issue(1'b0, make_adr(space, i % 8), 4'h0, 32'h0);
    end

    // register bank with a look at each wait state
    for (int i = 0; i < 4; i++) begin
      issue(1'b1, make_adr(1'b1, i), 4'hf, $urandom);
      wait_state_check();
    end
    for (int i = 0; i < 4; i++) begin
      issue(1'b0, make_adr(1'b1, i), 4'hf, 32'h0);
      wait_state_check();
    end

    // random back to back mix over the initialized words
    for (int i = 0; i < 200; i++) begin
      r = $urandom;
      space = r[0];
      word = space ? int'(r[2:1]) : int'(r[4:1]);
      issue(r[5], make_adr(space, word), r[9:6], $urandom);
    end

    // drain outstanding reads
    vld <= 1'b0;
    for (int n = 0; n < 10 * (DLY + 2) && exp_q.size() != 0; n++) begin
      @(posedge sub);
    end
    if (exp_q.size() != 0) begin
      stop_run($sformatf("%0d read responses missing at end of run", exp_q.size()));
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

endmodule : tcb_subsystem_tb

`default_nettype wire

//--- verilog/tcb_decoder.sv
// TCB address decoder and response mux
`timescale 1ns/100ps
`default_nettype none

module tcb_decoder
  import tcb_pkg::*;
#(
  // response delay of both subordinates
  parameter int DLY = TCB_DLY
)(
  input  logic     sub,
  input  logic     rst_n,
  // request from the register slice
  input  logic     man_vld,
  output logic     man_rdy,
  input  logic     man_wen,
  input  tcb_adr_t man_adr,
  input  tcb_ben_t man_ben,
  input  tcb_dat_t man_wdt,
  // response toward the outside
  output logic     rsp_vld,
  output tcb_dat_t rdt,
  // sram port
  output logic     mem_vld,
  input  logic     mem_rdy,
  output logic     mem_wen,
  output tcb_adr_t mem_adr,
  output tcb_ben_t mem_ben,
  output tcb_dat_t mem_wdt,
  input  tcb_dat_t mem_rdt,
  // scratch register port
  output logic     reg_vld,
  input  logic     reg_rdy,
  output logic     reg_wen,
  output tcb_adr_t reg_adr,
  output tcb_ben_t reg_ben,
  output tcb_dat_t reg_wdt,
  input  tcb_dat_t reg_rdt
);

  // address bit 15 picks the scratch registers
  logic sel;
  // handshake at this decoder
  logic trn;
  // per stage select and read flag of past transfers
  logic [DLY-1:0] sel_q;
  logic [DLY-1:0] rd_q;

  //////////////////////////////
  // request steering
  //////////////////////////////

  assign sel = man_adr[15];

  // only the selected subordinate sees valid
  assign mem_vld = man_vld & ~sel;
  assign reg_vld = man_vld &  sel;

  // request fields are shared by both ports
  assign mem_wen = man_wen;
  assign mem_adr = man_adr;
  assign mem_ben = man_ben;
  assign mem_wdt = man_wdt;
  assign reg_wen = man_wen;
  assign reg_adr = man_adr;
  assign reg_ben = man_ben;
  assign reg_wdt = man_wdt;

  // an empty slot is always ready, so the slice can refill it
  // otherwise ready comes from whichever subordinate is addressed
  assign man_rdy = ~man_vld | (sel ? reg_rdy : mem_rdy);

  assign trn = man_vld & man_rdy;

  //////////////////////////////
  // response tracking
  //////////////////////////////

  // both flags march along with the subordinate read pipelines
  always_ff @(posedge sub or negedge rst_n) begin
    if (!rst_n) begin
      sel_q <= '0;
      rd_q  <= '0;
    end else begin
      sel_q[0] <= sel;
      rd_q[0]  <= trn & ~man_wen;
      for (int i = 1; i < DLY; i++) begin
        sel_q[i] <= sel_q[i-1];
        rd_q[i]  <= rd_q[i-1];
      end
    end
  end

  // last stage lines up with the read data of the transfer
  assign rsp_vld = rd_q[DLY-1];
  assign rdt     = sel_q[DLY-1] ? reg_rdt : mem_rdt;

endmodule : tcb_decoder

`default_nettype wire

//--- verilog/tcb_register_request.sv
// TCB request register slice
`timescale 1ns/100ps
`default_nettype none

module tcb_register_request
  import tcb_pkg::*;
(
  // clock and reset
  input  logic     sub,
  input  logic     rst_n,
  // input side, the manager connects here
  input  logic     sub_vld,
  output logic     sub_rdy,
  input  logic     sub_wen,
  input  tcb_adr_t sub_adr,
  input  tcb_ben_t sub_ben,
  input  tcb_dat_t sub_wdt,
  // output side, toward the decoder
  output logic     man_vld,
  input  logic     man_rdy,
  output logic     man_wen,
  output tcb_adr_t man_adr,
  output tcb_ben_t man_ben,
  output tcb_dat_t man_wdt
);

  //////////////////////////////
  // valid register
  //////////////////////////////

  // the slot is refilled whenever downstream takes the old item
  // an empty slot also counts, since downstream reports ready then
  always_ff @(posedge sub or negedge rst_n) begin
    if (!rst_n) begin
      man_vld <= 1'b0;
    end else if (man_rdy) begin
      man_vld <= sub_vld;
    end
  end

  //////////////////////////////
  // request fields
  //////////////////////////////

  // same load condition as valid
  // contents only matter while man_vld is high
  always_ff @(posedge sub) begin
    if (man_rdy) begin
      // transfer direction
      man_wen <= sub_wen;
      // byte address
      man_adr <= sub_adr;
      // lane enables
      man_ben <= sub_ben;
      // write payload
      man_wdt <= sub_wdt;
    end
  end

  //////////////////////////////
  // backpressure
  //////////////////////////////

  // ready goes straight back, no register in this direction
  // a stalled output blocks the input on the same cycle
  assign sub_rdy = man_rdy;

endmodule : tcb_register_request

`default_nettype wire

//--- verilog/tcb_scratch_regs.sv
// TCB scratch register bank
`timescale 1ns/100ps
`default_nettype none

module tcb_scratch_regs
  import tcb_pkg::*;
#(
  // response delay
  parameter int DLY = TCB_DLY
)(
  input  logic     sub,
  input  logic     rst_n,
  input  logic     vld,
  output logic     rdy,
  input  logic     wen,
  input  tcb_adr_t adr,
  input  tcb_ben_t ben,
  input  tcb_dat_t wdt,
  output tcb_dat_t rdt
);

  // register file, four words
  tcb_dat_t regs_q [4];
  // register select from address bits 3:2
  logic [1:0] idx;
  // wait state done, access may complete
  logic ack_q;
  logic trn;
  // read pipeline flags and data
  logic [DLY-1:0] vld_q;
  tcb_dat_t       dat_q [DLY];

  assign idx = adr[3:2];

  //////////////////////////////
  // wait state
  //////////////////////////////

  // first cycle of vld sets the flag, the transfer cycle clears it
  // so every access is two cycles and rdy restarts low
  always_ff @(posedge sub or negedge rst_n) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
    end else if (vld) begin
      ack_q <= ~ack_q;
    end
  end

  assign rdy = ack_q;
  assign trn = vld & rdy;

  //////////////////////////////
  // registers
  //////////////////////////////

  // byte lane writes, cleared on reset
  always_ff @(posedge sub or negedge rst_n) begin
    if (!rst_n) begin
      for (int r = 0; r < 4; r++) regs_q[r] <= '0;
    end else if (trn && wen) begin
      for (int b = 0; b < TCB_BEW; b++) begin
        if (ben[b]) regs_q[idx][8*b +: 8] <= wdt[8*b +: 8];
      end
    end
  end

  //////////////////////////////
  // read pipeline
  //////////////////////////////

  always_ff @(posedge sub or negedge rst_n) begin
    if (!rst_n) begin
      vld_q <= '0;
    end else begin
      vld_q[0] <= trn & ~wen;
      for (int i = 1; i < DLY; i++) vld_q[i] <= vld_q[i-1];
    end
  end

  always_ff @(posedge sub) begin
    if (trn && !wen) dat_q[0] <= regs_q[idx];
    for (int i = 1; i < DLY; i++) begin
      if (vld_q[i-1]) dat_q[i] <= dat_q[i-1];
    end
  end

  // zero when no response is due
  assign rdt = vld_q[DLY-1] ? dat_q[DLY-1] : '0;

endmodule : tcb_scratch_regs

`default_nettype wire

//--- verilog/tcb_sram.sv
// TCB byte-enabled SRAM
`timescale 1ns/100ps
`default_nettype none

module tcb_sram
  import tcb_pkg::*;
#(
  // response delay
  parameter int DLY        = TCB_DLY,
  // number of data words, power of two
  parameter int SRAM_DEPTH = 256
)(
  input  logic     sub,
  input  logic     rst_n,
  input  logic     vld,
  output logic     rdy,
  input  logic     wen,
  input  tcb_adr_t adr,
  input  tcb_ben_t ben,
  input  tcb_dat_t wdt,
  output tcb_dat_t rdt
);

  // word index width
  localparam int IDW = $clog2(SRAM_DEPTH);

  // storage
  tcb_dat_t mem [SRAM_DEPTH];
  // word index, byte offset bits dropped
  logic [IDW-1:0] idx;
  // read and write transfers
  logic wr_trn;
  logic rd_trn;
  // read pipeline, flag marks a live word in that stage
  logic [DLY-1:0] vld_q;
  tcb_dat_t       dat_q [DLY];

  // never stalls
  assign rdy = 1'b1;

  assign idx    = adr[IDW+1:2];
  assign wr_trn = vld & rdy &  wen;
  assign rd_trn = vld & rdy & ~wen;

  //////////////////////////////
  // write port
  //////////////////////////////

  // lanes with ben low keep their old byte
  always_ff @(posedge sub) begin
    if (wr_trn) begin
      for (int b = 0; b < TCB_BEW; b++) begin
        if (ben[b]) mem[idx][8*b +: 8] <= wdt[8*b +: 8];
      end
    end
  end

  //////////////////////////////
  // read pipeline
  //////////////////////////////

  always_ff @(posedge sub or negedge rst_n) begin
    if (!rst_n) begin
      vld_q <= '0;
    end else begin
      vld_q[0] <= rd_trn;
      for (int i = 1; i < DLY; i++) vld_q[i] <= vld_q[i-1];
    end
  end

  // data stages only move when they carry a read
  always_ff @(posedge sub) begin
    if (rd_trn) dat_q[0] <= mem[idx];
    for (int i = 1; i < DLY; i++) begin
      if (vld_q[i-1]) dat_q[i] <= dat_q[i-1];
    end
  end

  // bus stays at zero between responses
  assign rdt = vld_q[DLY-1] ? dat_q[DLY-1] : '0;

endmodule : tcb_sram

`default_nettype wire

//--- verilog/tcb_subsystem.sv
// TCB subsystem top level
`timescale 1ns/100ps
`default_nettype none

module tcb_subsystem
  import tcb_pkg::*;
#(
  // response delay of the subordinates
  parameter int DLY        = TCB_DLY,
  // sram size in words
  parameter int SRAM_DEPTH = 256
)(
  input  logic     sub,
  input  logic     rst_n,
  // request from the outside manager
  input  logic     vld,
  output logic     rdy,
  input  logic     wen,
  input  tcb_adr_t adr,
  input  tcb_ben_t ben,
  input  tcb_dat_t wdt,
  // response, rsp_vld flags each read word
  output logic     rsp_vld,
  output tcb_dat_t rdt
);

  //////////////////////////////
  // internal buses
  //////////////////////////////

  // slice to decoder
  logic     slc_vld, slc_rdy, slc_wen;
  tcb_adr_t slc_adr;
  tcb_ben_t slc_ben;
  tcb_dat_t slc_wdt;
  // decoder to sram
  logic     mem_vld, mem_rdy, mem_wen;
  tcb_adr_t mem_adr;
  tcb_ben_t mem_ben;
  tcb_dat_t mem_wdt, mem_rdt;
  // decoder to scratch registers
  logic     reg_vld, reg_rdy, reg_wen;
  tcb_adr_t reg_adr;
  tcb_ben_t reg_ben;
  tcb_dat_t reg_wdt, reg_rdt;

  //////////////////////////////
  // instances
  //////////////////////////////

  tcb_register_request u_register_request (
    .sub, .rst_n,
    .sub_vld (vld),     .sub_rdy (rdy),     .sub_wen (wen),
    .sub_adr (adr),     .sub_ben (ben),     .sub_wdt (wdt),
    .man_vld (slc_vld), .man_rdy (slc_rdy), .man_wen (slc_wen),
    .man_adr (slc_adr), .man_ben (slc_ben), .man_wdt (slc_wdt)
  );

  tcb_decoder #(.DLY (DLY)) u_decoder (
    .sub, .rst_n,
    .man_vld (slc_vld), .man_rdy (slc_rdy), .man_wen (slc_wen),
    .man_adr (slc_adr), .man_ben (slc_ben), .man_wdt (slc_wdt),
    .rsp_vld, .rdt,
    .mem_vld, .mem_rdy, .mem_wen, .mem_adr, .mem_ben, .mem_wdt, .mem_rdt,
    .reg_vld, .reg_rdy, .reg_wen, .reg_adr, .reg_ben, .reg_wdt, .reg_rdt
  );

  tcb_sram #(.DLY (DLY), .SRAM_DEPTH (SRAM_DEPTH)) u_sram (
    .sub, .rst_n,
    .vld (mem_vld), .rdy (mem_rdy), .wen (mem_wen), .adr (mem_adr),
    .ben (mem_ben), .wdt (mem_wdt), .rdt (mem_rdt)
  );

  tcb_scratch_regs #(.DLY (DLY)) u_scratch_regs (
    .sub, .rst_n,
    .vld (reg_vld), .rdy (reg_rdy), .wen (reg_wen), .adr (reg_adr),
    .ben (reg_ben), .wdt (reg_wdt), .rdt (reg_rdt)
  );

endmodule : tcb_subsystem

`default_nettype wire
